// File: fetch_ctrl.sv
module fetch_ctrl (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic                         req_valid,
  output logic                         req_ready,
  input  graph_pkg::fetch_req_t        req,
  output logic                         attr_start,
  output logic [graph_pkg::ADDR_W-1:0] attr_base,
  output logic                         neigh_start,
  output logic [graph_pkg::ADDR_W-1:0] neigh_base,
  input  logic                         attr_done,
  input  logic                         attr_error,
  input  logic                         neigh_done,
  input  logic [graph_pkg::CNT_W-1:0]  neigh_count,
  input  logic                         neigh_error,
  output logic                         status_valid,
  input  logic                         status_ready,
  output graph_pkg::fetch_status_t     status
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_REPORT
  } state_t;

  state_t                        state;
  logic                          accept;
  logic                          attr_seen;
  logic                          neigh_seen;
  logic                          attr_fin;
  logic                          neigh_fin;
  logic                          attr_err_q;
  logic                          neigh_err_q;
  logic [graph_pkg::CNT_W-1:0]   count_q;

  assign req_ready = (state == S_IDLE);
  assign accept = req_valid && req_ready;

  // both issuers start in the accept cycle so reads go out on the next one
  assign attr_start = accept;
  assign neigh_start = accept;

  // header word at the base is skipped
  assign attr_base = req.addr + graph_pkg::ADDR_W'(1);
  assign neigh_base = req.addr + graph_pkg::ADDR_W'(1 + graph_pkg::DIM);

  // done pulses can arrive in either order, or together
  assign attr_fin = attr_seen || attr_done;
  assign neigh_fin = neigh_seen || neigh_done;

  assign status_valid = (state == S_REPORT);

  always_comb begin
    status.count = count_q;
    status.error = attr_err_q || neigh_err_q;
  end

  always_ff @(posedge clk_in) begin
    if (neigh_done) begin
      count_q <= neigh_count;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= S_IDLE;
      attr_seen <= 1'b0;
      neigh_seen <= 1'b0;
      attr_err_q <= 1'b0;
      neigh_err_q <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (accept) begin
            attr_seen <= 1'b0;
            neigh_seen <= 1'b0;
            attr_err_q <= 1'b0;
            neigh_err_q <= 1'b0;
            state <= S_FETCH;
          end
        end
        S_FETCH: begin
          if (attr_done) begin
            attr_seen <= 1'b1;
            attr_err_q <= attr_error;
          end
          if (neigh_done) begin
            neigh_seen <= 1'b1;
            neigh_err_q <= neigh_error;
          end
          if (attr_fin && neigh_fin) begin
            state <= S_REPORT;
          end
        end
        S_REPORT: begin
          // hold the status until the consumer takes it
          if (status_ready) begin
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

// File: graph_fetch.sv
module graph_fetch (
  input  logic                         clk_in,
  input  logic                         rst_in,
  // vertex requests
  input  logic                         req_valid,
  output logic                         req_ready,
  input  graph_pkg::fetch_req_t        req,
  // attribute and neighbor streams
  output logic                         attr_valid,
  input  logic                         attr_ready,
  output graph_pkg::attr_beat_t        attr,
  output logic                         neigh_valid,
  input  logic                         neigh_ready,
  output logic [graph_pkg::DATA_W-1:0] neigh,
  // completion
  output logic                         status_valid,
  input  logic                         status_ready,
  output graph_pkg::fetch_status_t     status,
  // attribute memory port
  output logic                         attr_mem_arvalid,
  input  logic                         attr_mem_arready,
  output graph_pkg::axil_ar_t          attr_mem_ar,
  input  logic                         attr_mem_rvalid,
  output logic                         attr_mem_rready,
  input  graph_pkg::axil_r_t           attr_mem_r,
  // neighbor memory port
  output logic                         neigh_mem_arvalid,
  input  logic                         neigh_mem_arready,
  output graph_pkg::axil_ar_t          neigh_mem_ar,
  input  logic                         neigh_mem_rvalid,
  output logic                         neigh_mem_rready,
  input  graph_pkg::axil_r_t           neigh_mem_r
);

  logic                                          attr_start;
  logic [graph_pkg::ADDR_W-1:0]                  attr_base;
  logic                                          attr_done;
  logic                                          attr_error;
  logic                                          attr_push;
  graph_pkg::attr_beat_t                         attr_push_data;
  logic [$clog2(graph_pkg::ATTR_DEPTH+1)-1:0]    attr_fill;

  logic                                          neigh_start;
  logic [graph_pkg::ADDR_W-1:0]                  neigh_base;
  logic                                          neigh_done;
  logic [graph_pkg::CNT_W-1:0]                   neigh_count;
  logic                                          neigh_error;
  logic                                          neigh_push;
  graph_pkg::attr_beat_t                         neigh_push_data;
  logic [$clog2(graph_pkg::NEIGH_DEPTH+1)-1:0]   neigh_fill;

  fetch_ctrl i_fetch_ctrl (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .req          (req),
    .attr_start   (attr_start),
    .attr_base    (attr_base),
    .neigh_start  (neigh_start),
    .neigh_base   (neigh_base),
    .attr_done    (attr_done),
    .attr_error   (attr_error),
    .neigh_done   (neigh_done),
    .neigh_count  (neigh_count),
    .neigh_error  (neigh_error),
    .status_valid (status_valid),
    .status_ready (status_ready),
    .status       (status)
  );

  // fixed length record, no terminator
  read_issuer #(
    .DEPTH        (graph_pkg::ATTR_DEPTH),
    .MAX_WORDS    (graph_pkg::DIM),
    .STOP_ON_ZERO (1'b0)
  ) attr_issuer (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .start      (attr_start),
    .base       (attr_base),
    .ar_valid   (attr_mem_arvalid),
    .ar_ready   (attr_mem_arready),
    .ar         (attr_mem_ar),
    .r_valid    (attr_mem_rvalid),
    .r_ready    (attr_mem_rready),
    .r          (attr_mem_r),
    .push       (attr_push),
    .push_data  (attr_push_data),
    .fifo_count (attr_fill),
    .done       (attr_done),
    .word_count (),
    .error      (attr_error)
  );

  read_issuer #(
    .DEPTH        (graph_pkg::NEIGH_DEPTH),
    .MAX_WORDS    (graph_pkg::NEIGH_MAX),
    .STOP_ON_ZERO (1'b1)
  ) neigh_issuer (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .start      (neigh_start),
    .base       (neigh_base),
    .ar_valid   (neigh_mem_arvalid),
    .ar_ready   (neigh_mem_arready),
    .ar         (neigh_mem_ar),
    .r_valid    (neigh_mem_rvalid),
    .r_ready    (neigh_mem_rready),
    .r          (neigh_mem_r),
    .push       (neigh_push),
    .push_data  (neigh_push_data),
    .fifo_count (neigh_fill),
    .done       (neigh_done),
    .word_count (neigh_count),
    .error      (neigh_error)
  );

  sync_fifo #(
    .T     (graph_pkg::attr_beat_t),
    .DEPTH (graph_pkg::ATTR_DEPTH)
  ) attr_fifo (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .push      (attr_push),
    .push_data (attr_push_data),
    .pop_valid (attr_valid),
    .pop_ready (attr_ready),
    .pop_data  (attr),
    .count     (attr_fill)
  );

  // neighbor words carry no index
  sync_fifo #(
    .T     (logic [graph_pkg::DATA_W-1:0]),
    .DEPTH (graph_pkg::NEIGH_DEPTH)
  ) neigh_fifo (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .push      (neigh_push),
    .push_data (neigh_push_data.data),
    .pop_valid (neigh_valid),
    .pop_ready (neigh_ready),
    .pop_data  (neigh),
    .count     (neigh_fill)
  );

endmodule

// File: graph_pkg.sv
package graph_pkg;

  // bus and word widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // attribute words per vertex record
  localparam int DIM = 2;

  // fifo depths, these bound the reads in flight on each port
  localparam int NEIGH_DEPTH = 8;
  localparam int ATTR_DEPTH = 4;

  // longer neighbor lists are cut off here
  localparam int NEIGH_MAX = 64;

  localparam int IDX_W = 4;
  localparam int CNT_W = 7;

  // axi4-lite read address channel payload
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [2:0]        prot;
  } axil_ar_t;

  // axi4-lite read data channel payload
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } axil_r_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } fetch_req_t;

  // attribute word tagged with its position in the record
  typedef struct packed {
    logic [IDX_W-1:0]  idx;
    logic [DATA_W-1:0] data;
  } attr_beat_t;

  typedef struct packed {
    logic [CNT_W-1:0] count;
    logic             error;
  } fetch_status_t;

endpackage

// File: read_issuer.sv
module read_issuer #(
  parameter int DEPTH = 8,
  parameter int MAX_WORDS = 64,
  parameter bit STOP_ON_ZERO = 1'b1
) (
  input  logic                              clk_in,
  input  logic                              rst_in,
  input  logic                              start,
  input  logic [graph_pkg::ADDR_W-1:0]      base,
  output logic                              ar_valid,
  input  logic                              ar_ready,
  output graph_pkg::axil_ar_t               ar,
  input  logic                              r_valid,
  output logic                              r_ready,
  input  graph_pkg::axil_r_t                r,
  output logic                              push,
  output graph_pkg::attr_beat_t             push_data,
  input  logic [$clog2(DEPTH+1)-1:0]        fifo_count,
  output logic                              done,
  output logic [graph_pkg::CNT_W-1:0]       word_count,
  output logic                              error
);

  localparam int OCNT_W = $clog2(DEPTH + 1);

  logic                          active;
  logic                          stopped;
  logic                          ar_hold;
  logic [graph_pkg::ADDR_W-1:0]  addr;
  logic [graph_pkg::CNT_W-1:0]   issued;
  logic [OCNT_W-1:0]             outstanding;
  logic [graph_pkg::IDX_W-1:0]   rx_idx;
  logic [OCNT_W:0]               credit_used;
  logic                          limit_hit;
  logic                          issue;
  logic                          resp;
  logic                          resp_err;
  logic                          resp_zero;
  logic                          stop_next;
  logic [OCNT_W-1:0]             out_next;
  logic [graph_pkg::CNT_W-1:0]   issued_next;
  logic                          finish;

  // reads in flight plus words waiting in the fifo must fit the fifo
  assign credit_used = {1'b0, outstanding} + {1'b0, fifo_count};
  assign limit_hit = (issued == graph_pkg::CNT_W'(MAX_WORDS));

  // a read already on the bus stays valid until taken, even after a stop
  assign ar_valid = active && (ar_hold ||
                    (!stopped && !limit_hit && credit_used < (OCNT_W + 1)'(DEPTH)));
  assign ar.addr = addr;
  assign ar.prot = 3'b000;
  assign issue = ar_valid && ar_ready;

  assign r_ready = 1'b1;
  assign resp = active && r_valid;
  assign resp_err = (r.resp != 2'b00);
  assign resp_zero = STOP_ON_ZERO && (r.data == '0);

  // words behind the terminator are dropped
  assign push = resp && !stopped && !resp_err && !resp_zero;
  assign push_data.idx = rx_idx;
  assign push_data.data = r.data;

  assign stop_next = stopped || (resp && !resp_err && resp_zero);
  assign issued_next = issued + graph_pkg::CNT_W'(issue);

  always_comb begin
    out_next = outstanding;
    if (issue && !resp) begin
      out_next = outstanding + OCNT_W'(1);
    end else if (resp && !issue) begin
      out_next = outstanding - OCNT_W'(1);
    end
  end

  // nothing left to issue and the last response just came in
  assign finish = active && (out_next == '0) && !(ar_valid && !ar_ready) &&
                  (stop_next || issued_next == graph_pkg::CNT_W'(MAX_WORDS));

  always_ff @(posedge clk_in) begin
    if (start) begin
      addr <= base;
    end else if (issue) begin
      addr <= addr + graph_pkg::ADDR_W'(1);
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      active <= 1'b0;
      stopped <= 1'b0;
      ar_hold <= 1'b0;
      issued <= '0;
      outstanding <= '0;
      rx_idx <= '0;
      word_count <= '0;
      error <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= finish;
      if (start) begin
        active <= 1'b1;
        stopped <= 1'b0;
        ar_hold <= 1'b0;
        issued <= '0;
        outstanding <= '0;
        rx_idx <= '0;
        word_count <= '0;
        error <= 1'b0;
      end else if (active) begin
        ar_hold <= ar_valid && !ar_ready;
        stopped <= stop_next;
        issued <= issued_next;
        outstanding <= out_next;
        if (resp) begin
          rx_idx <= rx_idx + graph_pkg::IDX_W'(1);
        end
        if (push) begin
          word_count <= word_count + graph_pkg::CNT_W'(1);
        end
        if (resp && !stopped && resp_err) begin
          error <= 1'b1;
        end
        if (finish) begin
          active <= 1'b0;
        end
      end
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# build the graph fetch testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_graph_fetch -f vlog.f -o sim_graph_fetch
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit $build_status
fi

./obj_dir/sim_graph_fetch
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation failed with status $sim_status"
  exit $sim_status
fi

exit 0

// File: sync_fifo.sv
module sync_fifo #(
  parameter type T = logic [31:0],
  parameter int DEPTH = 8
) (
  input  logic                       clk_in,
  input  logic                       rst_in,
  input  logic                       push,
  input  T                           push_data,
  output logic                       pop_valid,
  input  logic                       pop_ready,
  output T                           pop_data,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  T mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             pop;

  // push is never issued into a full fifo, the issuer reserves space first
  assign pop_valid = (count != '0);
  assign pop = pop_valid && pop_ready;
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk_in) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      // simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count <= count + CNT_BITS'(1);
      end else if (pop && !push) begin
        count <= count - CNT_BITS'(1);
      end
    end
  end

endmodule

// File: tb_graph_fetch.sv
module tb_graph_fetch;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MEM_WORDS = 256;
  localparam int WAIT_MAX = 2000;

  logic                         clk_in;
  logic                         rst_in;
  logic                         req_valid;
  logic                         req_ready;
  graph_pkg::fetch_req_t        req;
  logic                         attr_valid;
  logic                         attr_ready;
  graph_pkg::attr_beat_t        attr;
  logic                         neigh_valid;
  logic                         neigh_ready;
  logic [graph_pkg::DATA_W-1:0] neigh;
  logic                         status_valid;
  logic                         status_ready;
  graph_pkg::fetch_status_t     status;
  logic                         attr_mem_arvalid;
  logic                         attr_mem_arready;
  graph_pkg::axil_ar_t          attr_mem_ar;
  logic                         attr_mem_rvalid;
  logic                         attr_mem_rready;
  graph_pkg::axil_r_t           attr_mem_r;
  logic                         neigh_mem_arvalid;
  logic                         neigh_mem_arready;
  graph_pkg::axil_ar_t          neigh_mem_ar;
  logic                         neigh_mem_rvalid;
  logic                         neigh_mem_rready;
  graph_pkg::axil_r_t           neigh_mem_r;

  logic [graph_pkg::DATA_W-1:0] image [MEM_WORDS];
  logic [graph_pkg::ADDR_W-1:0] err_addr;
  int                           seed = 32'h0187_8f05;

  graph_fetch i_graph_fetch (
    .clk_in            (clk_in),
    .rst_in            (rst_in),
    .req_valid         (req_valid),
    .req_ready         (req_ready),
    .req               (req),
    .attr_valid        (attr_valid),
    .attr_ready        (attr_ready),
    .attr              (attr),
    .neigh_valid       (neigh_valid),
    .neigh_ready       (neigh_ready),
    .neigh             (neigh),
    .status_valid      (status_valid),
    .status_ready      (status_ready),
    .status            (status),
    .attr_mem_arvalid  (attr_mem_arvalid),
    .attr_mem_arready  (attr_mem_arready),
    .attr_mem_ar       (attr_mem_ar),
    .attr_mem_rvalid   (attr_mem_rvalid),
    .attr_mem_rready   (attr_mem_rready),
    .attr_mem_r        (attr_mem_r),
    .neigh_mem_arvalid (neigh_mem_arvalid),
    .neigh_mem_arready (neigh_mem_arready),
    .neigh_mem_ar      (neigh_mem_ar),
    .neigh_mem_rvalid  (neigh_mem_rvalid),
    .neigh_mem_rready  (neigh_mem_rready),
    .neigh_mem_r       (neigh_mem_r)
  );

  // both ports see the same memory image
  tb_graph_mem #(.WORDS(MEM_WORDS)) i_attr_mem (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .image    (image),
    .err_addr (err_addr),
    .arvalid  (attr_mem_arvalid),
    .arready  (attr_mem_arready),
    .ar       (attr_mem_ar),
    .rvalid   (attr_mem_rvalid),
    .rready   (attr_mem_rready),
    .r        (attr_mem_r)
  );

  tb_graph_mem #(.WORDS(MEM_WORDS)) i_neigh_mem (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .image    (image),
    .err_addr (err_addr),
    .arvalid  (neigh_mem_arvalid),
    .arready  (neigh_mem_arready),
    .ar       (neigh_mem_ar),
    .rvalid   (neigh_mem_rvalid),
    .rready   (neigh_mem_rready),
    .r        (neigh_mem_r)
  );

  initial begin
    clk_in = 1'b0;
    forever #4 clk_in = ~clk_in;
  end

  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic timeout_fail(input string what);
    $display("timeout while waiting for %s", what);
    stop_run();
  endtask

  task automatic check_attr(input string name, input graph_pkg::attr_beat_t exp,
                            input graph_pkg::attr_beat_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected idx %0d data %h, actual idx %0d data %h",
               name, exp.idx, exp.data, act.idx, act.data);
      stop_run();
    end
  endtask

  task automatic check_neigh(input string name, input logic [graph_pkg::DATA_W-1:0] exp,
                             input logic [graph_pkg::DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected neighbor %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_status(input string name, input graph_pkg::fetch_status_t exp,
                              input graph_pkg::fetch_status_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected count %0d error %b, actual count %0d error %b",
               name, exp.count, exp.error, act.count, act.error);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input logic [graph_pkg::ADDR_W-1:0] exp,
                            input logic [graph_pkg::ADDR_W-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected address %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  function automatic logic pick_ready(input bit stall);
    if (!stall) begin
      return 1'b1;
    end
    return ($random(seed) & 3) != 0;
  endfunction

  function automatic logic [graph_pkg::DATA_W-1:0] read_word(
    input logic [graph_pkg::ADDR_W-1:0] addr);
    return image[addr[7:0]];
  endfunction

  task automatic write_word(input logic [graph_pkg::ADDR_W-1:0] addr,
                            input logic [graph_pkg::DATA_W-1:0] value);
    image[addr[7:0]] = value;
  endtask

  // background never reads as a terminator
  task automatic fill_image();
    for (int a = 0; a < MEM_WORDS; a++) begin
      image[a] = 32'h5A00_0000 ^ (a * 32'h0001_0103);
    end
  endtask

  // header, DIM attributes, n_neigh neighbors, then the zero word
  task automatic load_vertex(input logic [graph_pkg::ADDR_W-1:0] base, input int n_neigh);
    logic [graph_pkg::ADDR_W-1:0] a;
    write_word(base, 32'h4EAD_0000 + base);
    for (int i = 0; i < graph_pkg::DIM; i++) begin
      write_word(base + 1 + i, 32'hA77A_0000 + (base << 4) + i);
    end
    a = base + 1 + graph_pkg::DIM;
    for (int k = 0; k < n_neigh; k++) begin
      write_word(a, 32'h0B00_0000 + (base << 8) + k + 1);
      a = a + 1;
    end
    write_word(a, '0);
  endtask

  task automatic fetch_vertex(input string name, input logic [graph_pkg::ADDR_W-1:0] base,
                              input bit stall);
    logic [graph_pkg::DATA_W-1:0] exp_words [$];
    logic [graph_pkg::ADDR_W-1:0] a;
    graph_pkg::attr_beat_t        exp_beat;
    graph_pkg::fetch_status_t     exp_status;
    logic                         exp_error;
    int                           waited;
    int                           n_attr;
    int                           n_neigh;
    bit                           status_done;
    bit                           ready_checked;

    // expected list: up to the first zero, failed word left out
    a = base + 1 + graph_pkg::DIM;
    exp_error = 1'b0;
    for (int k = 0; k < graph_pkg::NEIGH_MAX; k++) begin
      if (read_word(a) == '0) begin
        break;
      end
      if (a == err_addr) begin
        exp_error = 1'b1;
      end else begin
        exp_words.push_back(read_word(a));
      end
      a = a + 1;
    end
    exp_status.count = graph_pkg::CNT_W'(exp_words.size());
    exp_status.error = exp_error;

    @(posedge clk_in);
    req_valid <= 1'b1;
    req.addr <= base;
    waited = 0;
    @(negedge clk_in);
    while (!req_ready) begin
      waited++;
      if (waited > WAIT_MAX) begin
        timeout_fail({name, " request accept"});
      end
      @(negedge clk_in);
    end
    @(posedge clk_in);
    req_valid <= 1'b0;
    attr_ready <= pick_ready(stall);
    neigh_ready <= pick_ready(stall);
    status_ready <= pick_ready(stall);

    // first cycle after accept, both ports start reading
    @(negedge clk_in);
    check_flag({name, " attr arvalid"}, 1'b1, attr_mem_arvalid);
    check_flag({name, " neigh arvalid"}, 1'b1, neigh_mem_arvalid);
    check_addr({name, " attr first address"}, base + 1, attr_mem_ar.addr);
    check_addr({name, " neigh first address"}, base + 1 + graph_pkg::DIM,
               neigh_mem_ar.addr);

    n_attr = 0;
    n_neigh = 0;
    status_done = 1'b0;
    ready_checked = 1'b0;
    waited = 0;
    while (!ready_checked || attr_valid || neigh_valid) begin
      // space is reserved at issue time, so responses are never refused
      check_flag({name, " attr rready"}, 1'b1, attr_mem_rready);
      check_flag({name, " neigh rready"}, 1'b1, neigh_mem_rready);
      if (attr_valid && attr_ready) begin
        if (n_attr >= graph_pkg::DIM) begin
          $display("%s: attribute stream gave more beats than expected", name);
          stop_run();
        end
        exp_beat.idx = graph_pkg::IDX_W'(n_attr);
        exp_beat.data = read_word(base + 1 + n_attr);
        check_attr({name, " attribute"}, exp_beat, attr);
        n_attr++;
      end
      if (neigh_valid && neigh_ready) begin
        if (n_neigh >= exp_words.size()) begin
          $display("%s: neighbor stream gave more words than expected", name);
          stop_run();
        end
        check_neigh({name, " neighbor"}, exp_words[n_neigh], neigh);
        n_neigh++;
      end
      if (status_done && !ready_checked) begin
        check_flag({name, " req_ready after status"}, 1'b1, req_ready);
        ready_checked = 1'b1;
      end else if (!status_done) begin
        check_flag({name, " req_ready during fetch"}, 1'b0, req_ready);
      end
      if (status_valid && status_ready) begin
        check_status({name, " status"}, exp_status, status);
        status_done = 1'b1;
      end
      waited++;
      if (waited > WAIT_MAX) begin
        timeout_fail({name, " streams and status"});
      end
      @(posedge clk_in);
      attr_ready <= pick_ready(stall);
      neigh_ready <= pick_ready(stall);
      status_ready <= pick_ready(stall);
      @(negedge clk_in);
    end
    check_count({name, " attribute beats"}, graph_pkg::DIM, n_attr);
    check_count({name, " neighbor words"}, exp_words.size(), n_neigh);
  endtask

  task automatic test_attributes();
    load_vertex(8, 2);
    fetch_vertex("attributes", 8, 1'b0);
  endtask

  task automatic test_neighbors();
    load_vertex(40, 5);
    fetch_vertex("neighbor list", 40, 1'b0);
  endtask

  // twenty words through an eight deep fifo
  task automatic test_backpressure();
    load_vertex(64, 20);
    fetch_vertex("back-pressure", 64, 1'b1);
  endtask

  task automatic test_empty_list();
    load_vertex(100, 0);
    fetch_vertex("empty list", 100, 1'b0);
  endtask

  // error address set between edges, memory models sample it on the next one
  task automatic test_error();
    load_vertex(120, 6);
    err_addr = 120 + 1 + graph_pkg::DIM + 2;
    fetch_vertex("error response", 120, 1'b0);
    err_addr = '1;
  endtask

  task automatic test_back_to_back();
    load_vertex(150, 3);
    load_vertex(170, 5);
    load_vertex(200, 4);
    fetch_vertex("back-to-back first", 150, 1'b0);
    fetch_vertex("back-to-back second", 170, 1'b1);
    fetch_vertex("back-to-back third", 200, 1'b0);
  endtask

  initial begin
    rst_in = 1'b1;
    req_valid = 1'b0;
    req = '0;
    attr_ready = 1'b0;
    neigh_ready = 1'b0;
    status_ready = 1'b0;
    err_addr = '1;
    fill_image();
    repeat (3) @(posedge clk_in);
    rst_in <= 1'b0;

    @(negedge clk_in);
    check_flag("reset req_ready", 1'b1, req_ready);
    check_flag("reset attr arvalid", 1'b0, attr_mem_arvalid);
    check_flag("reset neigh arvalid", 1'b0, neigh_mem_arvalid);
    check_flag("reset attr_valid", 1'b0, attr_valid);
    check_flag("reset neigh_valid", 1'b0, neigh_valid);
    check_flag("reset status_valid", 1'b0, status_valid);

    test_attributes();
    test_neighbors();
    test_backpressure();
    test_empty_list();
    test_error();
    test_back_to_back();

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: tb_graph_mem.sv
module tb_graph_mem #(
  parameter int WORDS = 256
) (
  input  logic                         clk_in,
  input  logic                         rst_in,
  input  logic [graph_pkg::DATA_W-1:0] image [WORDS],
  input  logic [graph_pkg::ADDR_W-1:0] err_addr,
  input  logic                         arvalid,
  output logic                         arready,
  input  graph_pkg::axil_ar_t          ar,
  output logic                         rvalid,
  input  logic                         rready,
  output graph_pkg::axil_r_t           r
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int IDX_W = $clog2(WORDS);

  int                           seed = 32'h0187_8f05;
  int                           delay = 0;
  logic [graph_pkg::ADDR_W-1:0] pending [$];
  logic [graph_pkg::ADDR_W-1:0] addr;
  logic                         arready_q = 1'b0;
  logic                         rvalid_q = 1'b0;
  graph_pkg::axil_r_t           r_q = '0;

  assign arready = arready_q;
  assign rvalid = rvalid_q;
  assign r = r_q;

  // responses leave in request order, each after a random gap
  always @(posedge clk_in) begin
    if (rst_in) begin
      arready_q <= 1'b0;
      rvalid_q <= 1'b0;
      r_q <= '0;
      pending.delete();
      delay = 0;
    end else begin
      if (arvalid && arready_q) begin
        pending.push_back(ar.addr);
      end
      arready_q <= ($random(seed) & 3) != 0;
      if (!rvalid_q || rready) begin
        rvalid_q <= 1'b0;
        if (delay > 0) begin
          delay = delay - 1;
        end else if (pending.size() > 0) begin
          addr = pending.pop_front();
          // slave error with zero data at the chosen address
          if (addr == err_addr) begin
            r_q.data <= '0;
            r_q.resp <= 2'b10;
          end else begin
            r_q.data <= image[addr[IDX_W-1:0]];
            r_q.resp <= 2'b00;
          end
          rvalid_q <= 1'b1;
          delay = $random(seed) & 3;
        end
      end
    end
  end

endmodule

// File: vlog.f
graph_pkg.sv
sync_fifo.sv
read_issuer.sv
fetch_ctrl.sv
graph_fetch.sv
tb_graph_mem.sv
tb_graph_fetch.sv
